// ==== hdl/rd_engine_consts.svh ====
`ifndef RD_ENGINE_CONSTS_SVH
`define RD_ENGINE_CONSTS_SVH

// Channel count and channel index width
`define RD_NUM_CH      4
`define RD_CH_W        2

// AXI widths
`define RD_ADDR_W      32
`define RD_DATA_W      64
`define RD_ID_W        4

// Free-space count from the SRAM controller, in beats
`define RD_SPACE_W     8

// Scheduler remaining-beats and beats-done fields
`define RD_BEATS_W     32

// Fixed AXI codes, 8-byte beats and INCR bursts
`define RD_ARSIZE      3'd3
`define RD_BURST_INCR  2'b01
`define RD_RESP_OKAY   2'b00

`endif

// ==== hdl/rd_engine_pkg.sv ====
package rd_engine_pkg;

`include "rd_engine_consts.svh"

        // ================================================
        // Plain vector types
        // ================================================
        typedef logic [`RD_NUM_CH-1:0]  chan_mask_t;
        typedef logic [`RD_CH_W-1:0]    chan_id_t;
        typedef logic [`RD_ID_W-1:0]    axi_id_t;
        typedef logic [`RD_ADDR_W-1:0]  addr_t;
        typedef logic [`RD_DATA_W-1:0]  data_t;
        typedef logic [7:0]             arlen_t;   // Beats minus one
        typedef logic [`RD_BEATS_W-1:0] beats_t;
        typedef logic [`RD_SPACE_W-1:0] space_t;
        typedef logic [1:0]             resp_t;

        // ================================================
        // Bundles
        // ================================================
        // AR payload
        typedef struct packed {
                axi_id_t id;
                addr_t   addr;
                arlen_t  len;
        } ar_cmd_t;

        // Allocation request, 9-bit size so a 256-beat burst fits
        typedef struct packed {
                axi_id_t    id;
                logic [8:0] size;
        } alloc_t;

        // One R beat, also the SRAM write beat
        typedef struct packed {
                axi_id_t id;
                data_t   data;
                resp_t   resp;
                logic    last;
        } r_beat_t;

endpackage

// ==== hdl/rd_request_mask.sv ====
`timescale 1ns/1ns

`include "rd_engine_consts.svh"

module rd_request_mask
        import rd_engine_pkg::*;
(
        input  logic                       clk,
        input  logic                       rst_n,
        input  arlen_t                     cfg_xfer_len,
        input  chan_mask_t                 sched_valid,
        input  beats_t [`RD_NUM_CH-1:0]    sched_beats,
        input  space_t [`RD_NUM_CH-1:0]    space_free,
        input  logic                       ar_fire,
        input  chan_id_t                   grant_id,
        input  logic                       r_last_fire,
        input  chan_id_t                   r_last_ch,
        output arlen_t [`RD_NUM_CH-1:0]    xfer_len,
        output chan_mask_t                 arb_request
);

        // One read in flight per channel
        chan_mask_t outstanding;
        // Enough SRAM room for the sized burst
        chan_mask_t space_ok;

        // ================================================
        // Burst sizing and space check
        // ================================================
        always_comb begin
                for (int i = 0; i < `RD_NUM_CH; i++) begin
                        // Short tail takes what is left, else a full configured burst
                        if (sched_beats[i] <= beats_t'(cfg_xfer_len) + beats_t'(1)) begin
                                xfer_len[i] = arlen_t'(sched_beats[i] - beats_t'(1));
                        end else begin
                                xfer_len[i] = cfg_xfer_len;
                        end

                        // Compare in 9 bits, a 256-beat burst must not wrap
                        space_ok[i] = ({1'b0, space_free[i]} >= ({1'b0, xfer_len[i]} + 9'd1));
                end
        end

        // Scheduler request gated by room and by the in-flight flag
        assign arb_request = sched_valid & space_ok & ~outstanding;

        // ================================================
        // Outstanding flags
        // ================================================
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        outstanding <= '0;
                end else begin
                        for (int i = 0; i < `RD_NUM_CH; i++) begin
                                // Set once the AR for this channel is taken
                                if (ar_fire && (grant_id == chan_id_t'(i))) begin
                                        outstanding[i] <= 1'b1;
                                end
                                // Last beat back frees the channel, clear wins
                                if (r_last_fire && (r_last_ch == chan_id_t'(i))) begin
                                        outstanding[i] <= 1'b0;
                                end
                        end
                end
        end

        // Channel drops out of arbitration right after its AR is taken
        for (genvar g = 0; g < `RD_NUM_CH; g++) begin : gen_chk
                a_no_req_in_flight: assert property (
                        @(posedge clk) disable iff (!rst_n)
                        (ar_fire && (grant_id == chan_id_t'(g))) |=> !arb_request[g]
                );
        end

endmodule

// ==== hdl/rr_arbiter.sv ====
`timescale 1ns/1ns

`include "rd_engine_consts.svh"

module rr_arbiter
        import rd_engine_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  chan_mask_t request,
        input  chan_mask_t grant_ack,
        output logic       grant_valid,
        output chan_mask_t grant,
        output chan_id_t   grant_id
);

        // Highest-priority channel for the next pick
        chan_id_t ptr;
        // Channel named by the acknowledge vector
        chan_id_t ack_id;
        logic     ack_valid;

        // ================================================
        // Grant search from the pointer
        // ================================================
        always_comb begin
                int idx;
                grant_valid = 1'b0;
                grant       = '0;
                grant_id    = '0;
                // Walk the channels in priority order, first hit wins
                for (int off = 0; off < `RD_NUM_CH; off++) begin
                        idx = (int'(ptr) + off) % `RD_NUM_CH;
                        if (!grant_valid && request[idx]) begin
                                grant_valid   = 1'b1;
                                grant[idx]    = 1'b1;
                                grant_id      = chan_id_t'(idx);
                        end
                end
        end

        // Encode the one-hot acknowledge
        always_comb begin
                ack_valid = 1'b0;
                ack_id    = '0;
                for (int i = 0; i < `RD_NUM_CH; i++) begin
                        if (grant_ack[i]) begin
                                ack_valid = 1'b1;
                                ack_id    = chan_id_t'(i);
                        end
                end
        end

        // ================================================
        // Pointer update
        // ================================================
        // Held until the command is taken, so a stalled grant stays put
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        ptr <= '0;
                end else if (ack_valid) begin
                        ptr <= chan_id_t'((int'(ack_id) + 1) % `RD_NUM_CH);
                end
        end

        // At most one winner
        a_grant_onehot: assert property (
                @(posedge clk) disable iff (!rst_n) $onehot0(grant)
        );

        // Winner is always a live request
        a_grant_in_req: assert property (
                @(posedge clk) disable iff (!rst_n) (grant & ~request) == '0
        );

endmodule

// ==== hdl/rd_issue_ctrl.sv ====
`timescale 1ns/1ns

`include "rd_engine_consts.svh"

module rd_issue_ctrl
        import rd_engine_pkg::*;
(
        input  logic                       clk,
        input  logic                       rst_n,
        input  logic                       grant_valid,
        input  chan_mask_t                 grant,
        input  chan_id_t                   grant_id,
        input  arlen_t [`RD_NUM_CH-1:0]    xfer_len,
        input  addr_t  [`RD_NUM_CH-1:0]    sched_addr,
        input  logic                       arready,
        output logic                       arvalid,
        output ar_cmd_t                    ar,
        output logic                       ar_fire,
        output chan_mask_t                 grant_ack,
        output logic                       alloc_req,
        output alloc_t                     alloc,
        output chan_mask_t                 done_strobe,
        output beats_t [`RD_NUM_CH-1:0]    beats_done
);

        // ================================================
        // AR command
        // ================================================
        // Valid follows the grant directly and drops with it
        assign arvalid = grant_valid;

        always_comb begin
                // Channel number in the low ID bits
                ar.id   = axi_id_t'(grant_id);
                // Scheduler keeps the address current
                ar.addr = sched_addr[grant_id];
                ar.len  = xfer_len[grant_id];
        end

        assign ar_fire = arvalid && arready;

        // Acknowledge the winner only on the handshake
        assign grant_ack = grant & {`RD_NUM_CH{ar_fire}};

        // ================================================
        // Allocation and completion pulses
        // ================================================
        // One-cycle pulses after each taken command
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        alloc_req   <= 1'b0;
                        done_strobe <= '0;
                end else begin
                        alloc_req   <= ar_fire;
                        done_strobe <= grant_ack;
                end
        end

        // Payload next to the pulses
        always_ff @(posedge clk) begin
                if (ar_fire) begin
                        alloc.id   <= axi_id_t'(grant_id);
                        alloc.size <= {1'b0, xfer_len[grant_id]} + 9'd1;
                        // Beats handed to the bus for this channel
                        beats_done[grant_id] <= beats_t'(xfer_len[grant_id]) + beats_t'(1);
                end
        end

        // Every allocation follows a taken AR and pairs with its channel's done strobe
        a_alloc_after_ar: assert property (
                @(posedge clk) disable iff (!rst_n)
                alloc_req |-> ($past(ar_fire) && (done_strobe == (chan_mask_t'(1) << alloc.id)))
        );

endmodule

// ==== hdl/rd_data_path.sv ====
`timescale 1ns/1ns

`include "rd_engine_consts.svh"

module rd_data_path
        import rd_engine_pkg::*;
(
        input  logic       clk,
        input  logic       rst_n,
        input  logic       rvalid,
        input  r_beat_t    r,
        output logic       rready,
        output logic       sram_valid,
        output r_beat_t    sram_beat,
        input  logic       sram_ready,
        output logic       r_last_fire,
        output chan_id_t   r_last_ch,
        output chan_mask_t rd_error
);

        logic     r_fire;
        chan_id_t beat_ch;

        // ================================================
        // Streaming, no buffer
        // ================================================
        // SRAM back-pressure goes straight to the bus
        assign rready     = sram_ready;
        assign sram_valid = rvalid;
        assign sram_beat  = r;

        assign r_fire  = rvalid && rready;
        // Channel rides in the low ID bits
        assign beat_ch = r.id[`RD_CH_W-1:0];

        // Burst end for the outstanding tracker
        assign r_last_fire = r_fire && r.last;
        assign r_last_ch   = beat_ch;

        // Sticky error per channel, any non-OKAY beat
        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        rd_error <= '0;
                end else if (r_fire && (r.resp != `RD_RESP_OKAY)) begin
                        rd_error[beat_ch] <= 1'b1;
                end
        end

endmodule

// ==== hdl/axi_read_engine.sv ====
`timescale 1ns/1ns

`include "rd_engine_consts.svh"

module axi_read_engine
        import rd_engine_pkg::*;
(
        input  logic                       clk,
        input  logic                       rst_n,

        // Burst length, level, held during traffic
        input  arlen_t                     cfg_xfer_len,

        // Scheduler requests
        input  chan_mask_t                 sched_rd_valid,
        input  addr_t  [`RD_NUM_CH-1:0]    sched_rd_addr,
        input  beats_t [`RD_NUM_CH-1:0]    sched_rd_beats,

        // Scheduler completion and errors
        output chan_mask_t                 sched_rd_done_strobe,
        output beats_t [`RD_NUM_CH-1:0]    sched_rd_beats_done,
        output chan_mask_t                 sched_rd_error,

        // SRAM allocation
        output logic                       alloc_req,
        output alloc_t                     alloc,
        input  space_t [`RD_NUM_CH-1:0]    space_free,

        // SRAM write stream
        output logic                       sram_valid,
        input  logic                       sram_ready,
        output r_beat_t                    sram_beat,

        // AXI AR
        output logic                       arvalid,
        input  logic                       arready,
        output ar_cmd_t                    ar,
        output logic [2:0]                 arsize,
        output logic [1:0]                 arburst,

        // AXI R
        input  logic                       rvalid,
        output logic                       rready,
        input  r_beat_t                    r
);

        // ================================================
        // Internal wiring
        // ================================================
        chan_mask_t                 arb_request;
        arlen_t [`RD_NUM_CH-1:0]    xfer_len;
        logic                       grant_valid;
        chan_mask_t                 grant;
        chan_id_t                   grant_id;
        chan_mask_t                 grant_ack;
        logic                       ar_fire;
        logic                       r_last_fire;
        chan_id_t                   r_last_ch;

        // Fixed beat size and burst type
        assign arsize  = `RD_ARSIZE;
        assign arburst = `RD_BURST_INCR;

        // Eligibility, sizing and in-flight tracking
        rd_request_mask u_mask (
                .clk          (clk),
                .rst_n        (rst_n),
                .cfg_xfer_len (cfg_xfer_len),
                .sched_valid  (sched_rd_valid),
                .sched_beats  (sched_rd_beats),
                .space_free   (space_free),
                .ar_fire      (ar_fire),
                .grant_id     (grant_id),
                .r_last_fire  (r_last_fire),
                .r_last_ch    (r_last_ch),
                .xfer_len     (xfer_len),
                .arb_request  (arb_request)
        );

        rr_arbiter u_arb (
                .clk          (clk),
                .rst_n        (rst_n),
                .request      (arb_request),
                .grant_ack    (grant_ack),
                .grant_valid  (grant_valid),
                .grant        (grant),
                .grant_id     (grant_id)
        );

        // AR issue plus alloc and done pulses
        rd_issue_ctrl u_issue (
                .clk          (clk),
                .rst_n        (rst_n),
                .grant_valid  (grant_valid),
                .grant        (grant),
                .grant_id     (grant_id),
                .xfer_len     (xfer_len),
                .sched_addr   (sched_rd_addr),
                .arready      (arready),
                .arvalid      (arvalid),
                .ar           (ar),
                .ar_fire      (ar_fire),
                .grant_ack    (grant_ack),
                .alloc_req    (alloc_req),
                .alloc        (alloc),
                .done_strobe  (sched_rd_done_strobe),
                .beats_done   (sched_rd_beats_done)
        );

        // R to SRAM and error flags
        rd_data_path u_data (
                .clk          (clk),
                .rst_n        (rst_n),
                .rvalid       (rvalid),
                .r            (r),
                .rready       (rready),
                .sram_valid   (sram_valid),
                .sram_beat    (sram_beat),
                .sram_ready   (sram_ready),
                .r_last_fire  (r_last_fire),
                .r_last_ch    (r_last_ch),
                .rd_error     (sched_rd_error)
        );

endmodule

// ==== dv/tb_axi_read_engine.sv ====
`timescale 1ns/1ns

`include "rd_engine_consts.svh"

module tb_axi_read_engine
        import rd_engine_pkg::*;
();

        // Summed beats of all tests sets the cycle limit
        localparam int TOTAL_BEATS = 32 + 128 + 256 + 64;
        localparam int CYCLE_LIMIT = 4 * TOTAL_BEATS + 2000;

        logic clk;
        logic rst_n;
        arlen_t cfg_xfer_len;
        chan_mask_t sched_rd_valid;
        addr_t  [`RD_NUM_CH-1:0] sched_rd_addr;
        beats_t [`RD_NUM_CH-1:0] sched_rd_beats;
        chan_mask_t sched_rd_done_strobe;
        beats_t [`RD_NUM_CH-1:0] sched_rd_beats_done;
        chan_mask_t sched_rd_error;
        logic alloc_req;
        alloc_t alloc;
        space_t [`RD_NUM_CH-1:0] space_free;
        logic sram_valid;
        logic sram_ready;
        r_beat_t sram_beat;
        logic arvalid;
        logic arready;
        ar_cmd_t ar;
        logic [2:0] arsize;
        logic [1:0] arburst;
        logic rvalid;
        logic rready;
        r_beat_t r;

        axi_read_engine uut (.*);

        // ================================================
        // Clock, random source, checker
        // ================================================
        always #50 clk = ~clk;

        string cur_test;
        int errors;
        int cycles;
        logic [31:0] rng;

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1103515245 + 32'd12345;
        endfunction

        // Expected AXI length from the remaining beats
        function automatic arlen_t expected_len(input beats_t rem, input arlen_t cfg);
                if (longint'(rem) <= longint'(cfg) + 1)
                        return arlen_t'(rem - 1);
                return cfg;
        endfunction

        function automatic data_t beat_data(input addr_t addr, input int beat);
                addr_t a;
                a = addr + addr_t'(beat * 8);
                return {a, ~a};
        endfunction

        task automatic check(input string what, input logic [127:0] exp, input logic [127:0] act);
                if (exp !== act) begin
                        errors++;
                        $display("CHECK FAILED test=%s item=%s expected=%0h actual=%0h",
                                 cur_test, what, exp, act);
                        $display(">>> FAIL");
                        $fatal(1, "mismatch");
                end
        endtask

        // ================================================
        // Model state
        // ================================================
        // Slave burst queue
        int q_ch[$];
        addr_t q_addr[$];
        int q_len[$];
        int beat_idx;
        logic r_taken;
        // Expected in-flight flags, errors and pointer
        chan_mask_t out_model;
        chan_mask_t err_model;
        int rr_ptr;
        // AR taken in the previous cycle
        logic pend_fire;
        int pend_ch;
        int pend_len;
        // Scheduler update waiting for the next drive slot
        logic upd_valid;
        int upd_ch;
        int upd_beats;
        logic bad_en;
        int bad_ch;

        // ================================================
        // Compare process, mid-cycle where all outputs settle
        // ================================================
        always @(negedge clk) begin
                chan_mask_t elig;
                int exp_id;
                int ch;
                if (rst_n) begin
                        // Who should be eligible now
                        elig = '0;
                        for (int i = 0; i < `RD_NUM_CH; i++) begin
                                if (sched_rd_valid[i] && !out_model[i] &&
                                    int'(space_free[i]) >=
                                    int'(expected_len(sched_rd_beats[i], cfg_xfer_len)) + 1)
                                        elig[i] = 1'b1;
                        end
                        check("arvalid", elig != 0, arvalid);
                        check("arsize", 3, arsize);
                        check("arburst", 1, arburst);
                        check("error flags", err_model, sched_rd_error);

                        // Pulses one cycle after the handshake
                        if (pend_fire) begin
                                check("alloc_req", 1, alloc_req);
                                check("alloc id", pend_ch, alloc.id);
                                check("alloc size", pend_len + 1, alloc.size);
                                check("done strobe", 1 << pend_ch, sched_rd_done_strobe);
                                check("beats done", pend_len + 1, sched_rd_beats_done[pend_ch]);
                                upd_valid = 1'b1;
                                upd_ch    = pend_ch;
                                upd_beats = pend_len + 1;
                        end else begin
                                check("alloc_req idle", 0, alloc_req);
                                check("done strobe idle", 0, sched_rd_done_strobe);
                        end
                        pend_fire = 1'b0;

                        // AR handshake
                        if (arvalid && arready) begin
                                ch = int'(ar.id);
                                // A channel still in flight must not get a second AR
                                check("second AR in flight", 0, out_model[ch]);
                                exp_id = -1;
                                for (int off = 0; off < `RD_NUM_CH; off++) begin
                                        if (exp_id < 0 && elig[(rr_ptr + off) % `RD_NUM_CH])
                                                exp_id = (rr_ptr + off) % `RD_NUM_CH;
                                end
                                check("ar id", exp_id, ar.id);
                                check("ar len", expected_len(sched_rd_beats[ch], cfg_xfer_len),
                                      ar.len);
                                check("ar addr", sched_rd_addr[ch], ar.addr);
                                out_model[ch] = 1'b1;
                                rr_ptr = (ch + 1) % `RD_NUM_CH;
                                pend_fire = 1'b1;
                                pend_ch   = ch;
                                pend_len  = int'(ar.len);
                                q_ch.push_back(ch);
                                q_addr.push_back(ar.addr);
                                q_len.push_back(int'(ar.len));
                        end

                        // R path straight through
                        check("rready", sram_ready, rready);
                        check("sram_valid", rvalid, sram_valid);
                        if (rvalid && rready) begin
                                check("sram beat", r, sram_beat);
                                ch = int'(r.id[`RD_CH_W-1:0]);
                                if (r.resp != 2'b00)
                                        err_model[ch] = 1'b1;
                                if (r.last)
                                        out_model[ch] = 1'b0;
                                r_taken = 1'b1;
                        end
                end
        end

        // ================================================
        // Drive process, scheduler, slave and SRAM models
        // ================================================
        always @(posedge clk) begin
                #1;
                rng = lcg_next(rng);
                arready    = (rng[18:16] != 3'd0);
                sram_ready = (rng[22:21] != 2'd0);
                // Scheduler moves on after each completion
                if (upd_valid) begin
                        sched_rd_beats[upd_ch] = sched_rd_beats[upd_ch] - beats_t'(upd_beats);
                        sched_rd_addr[upd_ch]  = sched_rd_addr[upd_ch] + addr_t'(upd_beats * 8);
                        upd_valid = 1'b0;
                end
                for (int i = 0; i < `RD_NUM_CH; i++)
                        sched_rd_valid[i] = (sched_rd_beats[i] != 0);
                // Advance the slave beat pointer
                if (r_taken) begin
                        if (beat_idx == q_len[0]) begin
                                void'(q_ch.pop_front());
                                void'(q_addr.pop_front());
                                void'(q_len.pop_front());
                                beat_idx = 0;
                        end else begin
                                beat_idx++;
                        end
                        r_taken = 1'b0;
                end
                rvalid = (q_ch.size() != 0);
                r = '0;
                if (rvalid) begin
                        r.id   = axi_id_t'(q_ch[0]);
                        r.data = beat_data(q_addr[0], beat_idx);
                        r.resp = (bad_en && q_ch[0] == bad_ch) ? 2'b10 : 2'b00;
                        r.last = (beat_idx == q_len[0]);
                end
        end

        // Run limit
        always @(posedge clk) begin
                cycles++;
                if (cycles > CYCLE_LIMIT) begin
                        $display("Timeout: traffic did not finish within %0d cycles", CYCLE_LIMIT);
                        $display(">>> FAIL");
                        $fatal(1, "timeout");
                end
        end

        task automatic start_test(input string name, input int len,
                                  input int b0, input int b1, input int b2, input int b3);
                @(posedge clk);
                #1;
                cur_test = name;
                cfg_xfer_len = arlen_t'(len);
                sched_rd_beats[0] = beats_t'(b0);
                sched_rd_beats[1] = beats_t'(b1);
                sched_rd_beats[2] = beats_t'(b2);
                sched_rd_beats[3] = beats_t'(b3);
                for (int i = 0; i < `RD_NUM_CH; i++) begin
                        sched_rd_addr[i]  = addr_t'(32'h1000_0000 * (i + 1));
                        sched_rd_valid[i] = (sched_rd_beats[i] != 0);
                        space_free[i]     = space_t'(255);
                end
        endtask

        task automatic wait_idle();
                while (sched_rd_beats != '0 || q_ch.size() != 0 || out_model != 0 ||
                       pend_fire || upd_valid)
                        @(posedge clk);
        endtask

        // ================================================
        // Test sequence
        // ================================================
        initial begin
                clk = 1'b0;
                rst_n = 1'b0;
                cfg_xfer_len = '0;
                sched_rd_valid = '0;
                sched_rd_addr = '0;
                sched_rd_beats = '0;
                space_free = '0;
                sram_ready = 1'b0;
                arready = 1'b0;
                rvalid = 1'b0;
                r = '0;
                rng = 32'd80;
                errors = 0;
                cycles = 0;
                out_model = '0;
                err_model = '0;
                rr_ptr = 0;
                pend_fire = 1'b0;
                upd_valid = 1'b0;
                r_taken = 1'b0;
                beat_idx = 0;
                bad_en = 1'b0;
                bad_ch = 1;
                cur_test = "reset";
                repeat (16) @(posedge clk);
                #1;
                rst_n = 1'b1;

                // Short tails and full bursts
                start_test("burst_sizing", 7, 20, 8, 3, 1);
                wait_idle();

                // Channel 2 starved of SRAM room
                start_test("space_mask", 15, 32, 32, 32, 32);
                space_free[2] = space_t'(4);
                while (sched_rd_beats[0] != 0 || sched_rd_beats[1] != 0 ||
                       sched_rd_beats[3] != 0 || out_model != 0 || q_ch.size() != 0)
                        @(posedge clk);
                check("masked channel untouched", 32, sched_rd_beats[2]);
                @(posedge clk);
                #1;
                space_free[2] = space_t'(255);
                wait_idle();

                start_test("round_robin", 3, 64, 64, 64, 64);
                wait_idle();

                // Bad responses on channel 1 only
                start_test("read_errors", 7, 16, 16, 16, 16);
                bad_en = 1'b1;
                wait_idle();
                repeat (2) @(posedge clk);
                check("sticky error", 4'b0010, sched_rd_error);

                if (errors == 0) begin
                        $display(">>> PASS");
                        $finish;
                end else begin
                        $display(">>> FAIL");
                        $fatal(1, "errors seen");
                end
        end

endmodule

// ==== build.f ====
+incdir+hdl
hdl/rd_engine_pkg.sv
hdl/rd_request_mask.sv
hdl/rr_arbiter.sv
hdl/rd_issue_ctrl.sv
hdl/rd_data_path.sv
hdl/axi_read_engine.sv
dv/tb_axi_read_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -Wall -Wno-fatal \
        --top-module tb_axi_read_engine -f build.f -o sim_tb > sim.log 2>&1 \
        && ./obj_dir/sim_tb >> sim.log 2>&1

grep -q "^>>> PASS$" sim.log && echo "Simulation passed" && exit 0 \
        || { echo "Simulation failed, see sim.log"; exit 1; }
